// File: design/board_pkg.sv
package board_pkg;

  // ********************
  // startup register

  // mode 00 vector 24, 01 console, 10 boot from DX, 11 start at 140000
  localparam logic [1:0] STARTUP_MODE = 2'b01;  // enter console

  typedef struct packed {
    logic [7:0] start_page;  // high byte of the start address
    logic [3:0] spare;
    logic       rom_hi_en;   // upper rom banks
    logic       rom_lo_en;   // lower rom bank
    logic [1:0] start_mode;
  } startup_fields_t;

  typedef union packed {
    logic [15:0]     raw;     // as seen on the bus
    startup_fields_t fields;  // as used by the decode
  } startup_word_u;

  localparam logic [15:0] STARTUP_RESET   = {8'hE0, 4'h0, 1'b0, 1'b1, STARTUP_MODE};  // E005
  localparam logic [15:0] STARTUP_WR_MASK = 16'h00FC;  // only bits 7..2 writable

  // ********************
  // address map

  localparam logic [15:0] BOARD_REG_BASE = 16'o177714;  // SEL2 pair, then startup
  localparam logic [15:0] SYSRAM_BASE    = 16'o177600;
  localparam logic [15:0] SYSRAM_MASK    = 16'o177700;  // 64 byte window
  localparam logic [15:0] ROM_BASE       = 16'o160000;
  localparam int          ROM_WORDS      = 4096;        // 8 KB monitor

  localparam int    ROM_ACK_DELAY = 2;  // clocks from strobe to ack
  localparam string ROM_IMAGE     = "design/rom_image.mem";

  // ********************
  // line clock

  localparam logic TIMER_INIT = 1'b1;  // timer runs after power up

endpackage

// File: design/bus_decoder.sv
module bus_decoder
  import board_pkg::*;
(
  input  logic [15:0]   cpu_adr_i,
  input  logic          cpu_cyc_i,
  input  logic          cpu_stb_i,
  input  startup_word_u startup_i,     // bank enables live here
  input  logic [15:0]   rom_rdat_i,
  input  logic [15:0]   reg_rdat_i,
  input  logic [15:0]   bus_rdat_i,
  input  logic          rom_ack_i,
  input  logic          reg_ack_i,
  input  logic          bus_ack_i,
  output logic          rom_stb_o,
  output logic          reg_stb_o,
  output logic          bus_cyc_o,
  output logic          bus_stb_o,
  output logic          sysram_stb_o,
  output logic [15:0]   cpu_rdat_o,
  output logic          cpu_ack_o
);

  logic cpu_req;    // strobe inside an open cycle
  logic rom_win;    // whole 160000-177777 region
  logic bank_lo;
  logic bank_mid;
  logic bank_boot;
  logic rom_hit;
  logic reg_hit;
  logic ram_win;

  assign cpu_req = cpu_cyc_i & cpu_stb_i;

  // ********************
  // shadow rom banks
  assign rom_win   = (cpu_adr_i & ~16'(ROM_WORDS * 2 - 1)) == ROM_BASE;
  assign bank_lo   = (cpu_adr_i[12:11] == 2'b00) &
                     (startup_i.fields.rom_lo_en | startup_i.fields.rom_hi_en);  // 160000-163777
  assign bank_mid  = ((cpu_adr_i[12:11] == 2'b01) | (cpu_adr_i[12:11] == 2'b10)) &
                     startup_i.fields.rom_hi_en;                                  // 164000-173777
  assign bank_boot = cpu_adr_i[12:9] == 4'b1011;  // loader at 173000, never hidden
  assign rom_hit   = rom_win & (bank_lo | bank_mid | bank_boot);

  // board registers 177714-177717
  assign reg_hit = cpu_adr_i[15:2] == BOARD_REG_BASE[15:2];
  assign ram_win = (cpu_adr_i & SYSRAM_MASK) == SYSRAM_BASE;

  assign rom_stb_o = cpu_req & rom_hit;
  assign reg_stb_o = cpu_req & reg_hit;

  // outside bus only sees cycles nobody local claimed
  assign bus_cyc_o    = cpu_cyc_i & ~rom_hit & ~reg_hit;
  assign bus_stb_o    = bus_cyc_o & cpu_stb_i;
  assign sysram_stb_o = bus_stb_o & ram_win;

  // ********************
  // read data and reply
  always_comb begin
    if (rom_hit) begin
      cpu_rdat_o = rom_rdat_i;
    end else if (reg_hit) begin
      cpu_rdat_o = reg_rdat_i;
    end else begin
      cpu_rdat_o = bus_rdat_i;  // external devices
    end
  end

  assign cpu_ack_o = rom_ack_i | reg_ack_i | bus_ack_i;  // only one source active at a time

endmodule

// File: design/shadow_rom.sv
module shadow_rom
  import board_pkg::*;
(
  input  logic        clk_p,
  input  logic        arst_n_i,
  input  logic        rom_stb_i,
  input  logic [11:0] rom_adr_i,    // word address, cpu bits 12..1
  output logic [15:0] rom_rdat_o,
  output logic        rom_ack_o
);

  logic [15:0]              rom_mem [ROM_WORDS];
  logic [ROM_ACK_DELAY-1:0] ack_sr;  // one bit per wait clock

  // unused locations read as zero
  initial begin
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom_mem[i] = '0;
    end
    $readmemh(ROM_IMAGE, rom_mem);  // sparse image
  end

  // synchronous read, address held by the master
  always_ff @(posedge clk_p) begin
    rom_rdat_o <= rom_mem[rom_adr_i];
  end

  // ********************
  // reply after two clocks
  always_ff @(posedge clk_p or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_sr <= '0;
    end else if (!rom_stb_i) begin
      ack_sr <= '0;  // strobe gone, start over
    end else begin
      ack_sr <= {ack_sr[ROM_ACK_DELAY-2:0], 1'b1};
    end
  end

  // drop at once when the master lets go
  assign rom_ack_o = ack_sr[ROM_ACK_DELAY-1] & rom_stb_i;

endmodule

// File: design/board_registers.sv
module board_registers
  import board_pkg::*;
(
  input  logic          clk_p,
  input  logic          arst_n_i,
  input  logic          dclo_i,       // power-on clear from the supply
  input  logic          reg_stb_i,
  input  logic          cpu_we_i,
  input  logic [1:0]    cpu_adr_i,    // byte offset inside the window
  input  logic [15:0]   cpu_wdat_i,
  output logic [15:0]   reg_rdat_o,
  output logic          reg_ack_o,
  output startup_word_u startup_o,
  output logic [15:0]   sel2_o        // to the board switches
);

  logic [1:0]    reg_ofs;
  logic          reg_wr;
  logic [15:0]   sel2_even;
  logic [15:0]   sel2_odd;
  startup_word_u startup_q;

  assign reg_ofs = cpu_adr_i - BOARD_REG_BASE[1:0];  // 0/1 SEL2, 2 startup
  assign reg_wr  = reg_stb_i & cpu_we_i & ~reg_ack_o;  // once per cycle

  // ********************
  // single clock reply
  always_ff @(posedge clk_p or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_ack_o <= 1'b0;
    end else begin
      reg_ack_o <= reg_stb_i & ~reg_ack_o;  // one pulse per strobe
    end
  end

  always_ff @(posedge clk_p or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sel2_even     <= '0;
      sel2_odd      <= '0;
      startup_q.raw <= STARTUP_RESET;
    end else if (dclo_i) begin
      sel2_even     <= '0;  // reload before the cpu starts
      sel2_odd      <= '0;
      startup_q.raw <= STARTUP_RESET;
    end else if (reg_wr) begin
      if (reg_ofs[1]) begin
        // mode and start page stay fixed
        startup_q.raw <= (startup_q.raw & ~STARTUP_WR_MASK) | (cpu_wdat_i & STARTUP_WR_MASK);
      end else if (reg_ofs[0]) begin
        sel2_odd <= cpu_wdat_i;   // odd address copy
      end else begin
        sel2_even <= cpu_wdat_i;  // even address copy
      end
    end
  end

  assign reg_rdat_o = reg_ofs[1] ? startup_q.raw : (reg_ofs[0] ? sel2_odd : sel2_even);
  assign startup_o  = startup_q;
  assign sel2_o     = sel2_even;

endmodule

// File: design/line_clock.sv
module line_clock
  import board_pkg::*;
#(
  parameter int CLK_REF_HZ = 50_000_000  // board reference clock
) (
  input  logic clk_p,
  input  logic arst_n_i,
  input  logic timer_button_i,  // front panel on/off
  output logic timer_status_o,  // panel lamp
  output logic line_irq_o
);

  logic [$clog2(CLK_REF_HZ / 100)-1:0] div_cnt;
  logic                                div_wrap;
  logic                                timer_50;   // 50 Hz, half duty
  logic                                tick_rise;  // timer_50 about to go high
  logic [1:0]                          tb_shift;   // last two button samples
  logic [1:0]                          tb_next;
  logic                                tb_lock;    // held, wait for release

  // ********************
  // 50 Hz divider
  assign div_wrap = div_cnt == ($bits(div_cnt))'(CLK_REF_HZ / 100 - 1);

  always_ff @(posedge clk_p or negedge arst_n_i) begin
    if (!arst_n_i) begin
      div_cnt  <= '0;
      timer_50 <= 1'b0;
    end else if (div_wrap) begin
      div_cnt  <= '0;
      timer_50 <= ~timer_50;  // half period done
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign tick_rise = div_wrap & ~timer_50;
  assign tb_next   = {tb_shift[0], timer_button_i};

  // ********************
  // button debounce, sampled at 50 Hz
  always_ff @(posedge clk_p or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tb_shift       <= 2'b00;
      tb_lock        <= 1'b0;
      timer_status_o <= TIMER_INIT;
    end else if (tick_rise) begin
      tb_shift <= tb_next;
      if (&tb_next) begin  // pressed on two samples
        if (!tb_lock) begin
          timer_status_o <= ~timer_status_o;
          tb_lock        <= 1'b1;
        end
      end else if (~|tb_next) begin
        tb_lock <= 1'b0;  // released, re-arm
      end
    end
  end

  assign line_irq_o = timer_50 & timer_status_o;  // masked by the lamp state

endmodule

// File: design/cpu_board.sv
module cpu_board
  import board_pkg::*;
#(
  parameter int CLK_REF_HZ = 50_000_000
) (
  input  logic        clk_p,
  input  logic        arst_n_i,
  input  logic        dclo_i,
  // cpu master side
  input  logic        cpu_cyc_i,
  input  logic        cpu_stb_i,
  input  logic        cpu_we_i,
  input  logic [1:0]  cpu_sel_i,
  input  logic [15:0] cpu_adr_i,
  input  logic [15:0] cpu_wdat_i,
  output logic [15:0] cpu_rdat_o,
  output logic        cpu_ack_o,
  // external bus
  input  logic [15:0] bus_rdat_i,
  input  logic        bus_ack_i,
  output logic        bus_cyc_o,
  output logic        bus_stb_o,
  output logic        bus_we_o,
  output logic [1:0]  bus_sel_o,
  output logic [15:0] bus_adr_o,
  output logic [15:0] bus_wdat_o,
  output logic        sysram_stb_o,  // system ram 177600-177677
  // board
  output logic [15:0] sel2_o,
  input  logic        timer_button_i,
  output logic        timer_status_o,
  output logic        line_irq_o
);

  logic          rom_stb;
  logic          rom_ack;
  logic [15:0]   rom_rdat;
  logic          reg_stb;
  logic          reg_ack;
  logic [15:0]   reg_rdat;
  startup_word_u startup;

  // straight to the external bus
  assign bus_we_o   = cpu_we_i;
  assign bus_sel_o  = cpu_sel_i;
  assign bus_adr_o  = cpu_adr_i;
  assign bus_wdat_o = cpu_wdat_i;

  bus_decoder bus_decoder_i (
    .cpu_adr_i(cpu_adr_i), .cpu_cyc_i(cpu_cyc_i), .cpu_stb_i(cpu_stb_i),
    .startup_i(startup),
    .rom_rdat_i(rom_rdat), .reg_rdat_i(reg_rdat), .bus_rdat_i(bus_rdat_i),
    .rom_ack_i(rom_ack), .reg_ack_i(reg_ack), .bus_ack_i(bus_ack_i),
    .rom_stb_o(rom_stb), .reg_stb_o(reg_stb),
    .bus_cyc_o(bus_cyc_o), .bus_stb_o(bus_stb_o), .sysram_stb_o(sysram_stb_o),
    .cpu_rdat_o(cpu_rdat_o), .cpu_ack_o(cpu_ack_o)
  );

  shadow_rom shadow_rom_i (
    .clk_p(clk_p), .arst_n_i(arst_n_i),
    .rom_stb_i(rom_stb), .rom_adr_i(cpu_adr_i[12:1]),  // word address
    .rom_rdat_o(rom_rdat), .rom_ack_o(rom_ack)
  );

  board_registers board_registers_i (
    .clk_p(clk_p), .arst_n_i(arst_n_i), .dclo_i(dclo_i),
    .reg_stb_i(reg_stb), .cpu_we_i(cpu_we_i),
    .cpu_adr_i(cpu_adr_i[1:0]), .cpu_wdat_i(cpu_wdat_i),
    .reg_rdat_o(reg_rdat), .reg_ack_o(reg_ack),
    .startup_o(startup), .sel2_o(sel2_o)
  );

  line_clock #(.CLK_REF_HZ(CLK_REF_HZ)) line_clock_i (
    .clk_p(clk_p), .arst_n_i(arst_n_i), .timer_button_i(timer_button_i),
    .timer_status_o(timer_status_o), .line_irq_o(line_irq_o)
  );

endmodule

// File: test/cpu_board_tb.sv
module cpu_board_tb
  import board_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ns;

  localparam int CLK_HZ     = 2000;          // timer_50 half period of 20 clocks
  localparam int HALF_TICK  = CLK_HZ / 100;
  localparam int MAX_CYCLES = 20000;         // full run needs under 2000 clocks

  logic        clk_p;
  logic        arst_n_i;
  logic        dclo_i;
  logic        cpu_cyc_i;
  logic        cpu_stb_i;
  logic        cpu_we_i;
  logic [1:0]  cpu_sel_i;
  logic [15:0] cpu_adr_i;
  logic [15:0] cpu_wdat_i;
  logic [15:0] cpu_rdat_o;
  logic        cpu_ack_o;
  logic [15:0] bus_rdat_i = '0;
  logic        bus_ack_i = 1'b0;
  logic        bus_cyc_o;
  logic        bus_stb_o;
  logic        bus_we_o;
  logic [1:0]  bus_sel_o;
  logic [15:0] bus_adr_o;
  logic [15:0] bus_wdat_o;
  logic        sysram_stb_o;
  logic [15:0] sel2_o;
  logic        timer_button_i;
  logic        timer_status_o;
  logic        line_irq_o;

  logic [15:0] rom_ref [ROM_WORDS];  // expected rom contents
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          seed = 17095;
  logic [2:0]  slave_wait = '0;
  logic        slave_armed = 1'b0;
  // what the last bus cycle showed
  logic [15:0] rd_data;
  int          ack_waits;
  logic        saw_ext;
  logic        saw_stb;
  logic        saw_sysram;
  logic [15:0] ext_adr;
  logic [15:0] ext_wdat;
  logic        ext_we;
  logic [1:0]  ext_sel;

  cpu_board #(.CLK_REF_HZ(CLK_HZ)) cpu_board_i (
    .clk_p(clk_p), .arst_n_i(arst_n_i), .dclo_i(dclo_i),
    .cpu_cyc_i(cpu_cyc_i), .cpu_stb_i(cpu_stb_i), .cpu_we_i(cpu_we_i),
    .cpu_sel_i(cpu_sel_i), .cpu_adr_i(cpu_adr_i), .cpu_wdat_i(cpu_wdat_i),
    .cpu_rdat_o(cpu_rdat_o), .cpu_ack_o(cpu_ack_o),
    .bus_rdat_i(bus_rdat_i), .bus_ack_i(bus_ack_i),
    .bus_cyc_o(bus_cyc_o), .bus_stb_o(bus_stb_o), .bus_we_o(bus_we_o),
    .bus_sel_o(bus_sel_o), .bus_adr_o(bus_adr_o), .bus_wdat_o(bus_wdat_o),
    .sysram_stb_o(sysram_stb_o), .sel2_o(sel2_o),
    .timer_button_i(timer_button_i), .timer_status_o(timer_status_o),
    .line_irq_o(line_irq_o)
  );

  initial begin
    clk_p = 1'b0;
    forever #50 clk_p = ~clk_p;  // 100 ns period
  end

  // run limit
  always @(posedge clk_p) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: no end of test after %0d clock cycles", MAX_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  // ********************
  // external slave, 1 to 4 clocks
  always @(posedge clk_p) begin
    if (!arst_n_i || bus_ack_i) begin
      bus_ack_i   <= 1'b0;  // single clock reply
      slave_armed <= 1'b0;
    end else if (bus_stb_o) begin
      if (!slave_armed) begin
        slave_armed <= 1'b1;
        slave_wait  <= 3'($random(seed) & 32'h3);  // extra wait clocks
      end else if (slave_wait != 0) begin
        slave_wait <= slave_wait - 3'd1;
      end else begin
        bus_ack_i  <= 1'b1;
        bus_rdat_i <= bus_adr_o ^ 16'h5A5A;
      end
    end
  end

  function automatic logic in_sysram(input logic [15:0] adr);
    return (adr >= 16'o177600) && (adr <= 16'o177677);
  endfunction

  // ********************
  // bus invariants
  // the ram window is never claimed locally, so every strobe there goes out
  sysram_window: assert property (@(posedge clk_p) disable iff (!arst_n_i)
      sysram_stb_o == (cpu_cyc_i && cpu_stb_i && in_sysram(cpu_adr_i)))
    else begin
      $display("[ERROR] %0t sysram_stb_o got %b expected %b", $time, sysram_stb_o,
               cpu_cyc_i && cpu_stb_i && in_sysram(cpu_adr_i));
      errors++;
    end

  regs_stay_local: assert property (@(posedge clk_p) disable iff (!arst_n_i)
      (cpu_cyc_i && cpu_adr_i >= 16'o177714 && cpu_adr_i <= 16'o177717) |-> !bus_cyc_o)
    else begin
      $display("[ERROR] %0t bus_cyc_o got 1 expected 0", $time);
      errors++;
    end

  irq_masked: assert property (@(posedge clk_p) disable iff (!arst_n_i)
      !timer_status_o |-> !line_irq_o)
    else begin
      $display("[ERROR] %0t line_irq_o got 1 expected 0", $time);
      errors++;
    end

  ack_in_cycle: assert property (@(posedge clk_p) disable iff (!arst_n_i)
      cpu_ack_o |-> cpu_cyc_i)
    else begin
      $display("%0t: cpu_ack_o came with no cycle open", $time);
      errors++;
    end

  task automatic check_word(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    assert (got === exp)
      else begin
        $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        errors++;
      end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    assert (got === exp)
      else begin
        $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
        errors++;
      end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    assert (got == exp)
      else begin
        $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
        errors++;
      end
  endtask

  // ********************
  // one master cycle, held until ack
  task automatic bus_cycle(input logic [15:0] adr, input logic we, input logic [1:0] sel,
                           input logic [15:0] wdat);
    @(posedge clk_p);
    cpu_cyc_i  <= 1'b1;
    cpu_stb_i  <= 1'b1;
    cpu_we_i   <= we;
    cpu_sel_i  <= sel;
    cpu_adr_i  <= adr;
    cpu_wdat_i <= wdat;
    ack_waits  = 0;
    saw_ext    = 1'b0;
    saw_stb    = 1'b0;
    saw_sysram = 1'b0;
    do begin
      @(posedge clk_p);
      saw_ext    = saw_ext | bus_cyc_o;
      saw_stb    = saw_stb | bus_stb_o;
      saw_sysram = saw_sysram | sysram_stb_o;
      if (!cpu_ack_o) ack_waits++;  // clocks with no reply
    end while (!cpu_ack_o);
    rd_data  = cpu_rdat_o;
    ext_adr  = bus_adr_o;
    ext_wdat = bus_wdat_o;
    ext_we   = bus_we_o;
    ext_sel  = bus_sel_o;
    cpu_cyc_i <= 1'b0;  // end of cycle on the ack edge
    cpu_stb_i <= 1'b0;
    cpu_we_i  <= 1'b0;
  endtask

  task automatic read_expect(input logic [15:0] adr, input logic [15:0] exp, input string name);
    bus_cycle(adr, 1'b0, 2'b11, 16'h0000);
    check_word(name, rd_data, exp);
  endtask

  task automatic write_word(input logic [15:0] adr, input logic [15:0] data);
    bus_cycle(adr, 1'b1, 2'b11, data);
  endtask

  task automatic rom_read(input logic [15:0] adr);
    logic [11:0] word_ix;
    word_ix = 12'((adr - ROM_BASE) >> 1);
    bus_cycle(adr, 1'b0, 2'b11, 16'h0000);
    check_word("cpu_rdat_o (rom)", rd_data, rom_ref[word_ix]);
    check_count("rom ack delay", ack_waits, ROM_ACK_DELAY);
    check_bit("bus_cyc_o (rom)", saw_ext, 1'b0);
    check_bit("bus_stb_o (rom)", saw_stb, 1'b0);
  endtask

  task automatic ext_read(input logic [15:0] adr);
    bus_cycle(adr, 1'b0, 2'b11, 16'h0000);
    check_word("cpu_rdat_o (bus)", rd_data, adr ^ 16'h5A5A);
    check_bit("bus_cyc_o (bus)", saw_ext, 1'b1);
    check_bit("bus_stb_o (bus)", saw_stb, 1'b1);
    check_bit("sysram_stb_o", saw_sysram, in_sysram(adr));
  endtask

  task automatic ext_write(input logic [15:0] adr, input logic [15:0] data, input logic [1:0] sel);
    bus_cycle(adr, 1'b1, sel, data);
    check_bit("bus_we_o", ext_we, 1'b1);
    check_word("bus_adr_o", ext_adr, adr);
    check_word("bus_wdat_o", ext_wdat, data);
    check_word("bus_sel_o", {14'b0, ext_sel}, {14'b0, sel});
    check_bit("sysram_stb_o", saw_sysram, in_sysram(adr));
  endtask

  // ********************
  // line clock helpers
  task automatic irq_phases();
    int high_len;
    int low_len;
    high_len = 0;
    low_len  = 0;
    do begin
      @(posedge clk_p);
    end while (line_irq_o);
    do begin
      @(posedge clk_p);
    end while (!line_irq_o);  // now at a rising edge
    while (line_irq_o) begin
      high_len++;
      @(posedge clk_p);
    end
    while (!line_irq_o) begin
      low_len++;
      @(posedge clk_p);
    end
    check_count("line_irq_o high clocks", high_len, HALF_TICK);
    check_count("line_irq_o low clocks", low_len, HALF_TICK);
  endtask

  task automatic hold_button(input logic level, input int periods, output int irq_highs);
    irq_highs = 0;
    @(posedge clk_p);
    timer_button_i <= level;
    repeat (periods * 2 * HALF_TICK) begin
      @(posedge clk_p);
      if (line_irq_o) irq_highs++;
    end
  endtask

  initial begin
    startup_word_u exp_start;
    int            irq_highs;
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom_ref[i] = '0;  // gaps in the image read as zero
    end
    $readmemh(ROM_IMAGE, rom_ref);
    arst_n_i       <= 1'b0;
    dclo_i         <= 1'b0;
    cpu_cyc_i      <= 1'b0;
    cpu_stb_i      <= 1'b0;
    cpu_we_i       <= 1'b0;
    cpu_sel_i      <= 2'b00;
    cpu_adr_i      <= '0;
    cpu_wdat_i     <= '0;
    timer_button_i <= 1'b0;
    repeat (3) @(posedge clk_p);
    arst_n_i <= 1'b1;

    // startup register, mask and dclo
    read_expect(16'o177716, STARTUP_RESET, "startup after reset");
    check_count("reg ack delay", ack_waits, 1);
    write_word(16'o177716, 16'hFFFF);
    exp_start.raw = STARTUP_RESET | STARTUP_WR_MASK;
    read_expect(16'o177716, exp_start.raw, "startup after write");
    @(posedge clk_p);
    dclo_i <= 1'b1;
    repeat (2) @(posedge clk_p);
    dclo_i <= 1'b0;
    read_expect(16'o177716, STARTUP_RESET, "startup after dclo");

    // SEL2 even and odd copies
    write_word(16'o177714, 16'h1234);
    write_word(16'o177715, 16'hABCD);
    read_expect(16'o177714, 16'h1234, "sel2 even");
    read_expect(16'o177715, 16'hABCD, "sel2 odd");
    check_word("sel2_o", sel2_o, 16'h1234);
    write_word(16'o177714, 16'h0F0F);
    read_expect(16'o177715, 16'hABCD, "sel2 odd kept");
    check_word("sel2_o", sel2_o, 16'h0F0F);

    // ********************
    // shadow rom banks
    rom_read(16'o160000);
    rom_read(16'o160002);
    rom_read(16'o160010);
    rom_read(16'o173000);
    rom_read(16'o173002);
    ext_read(16'o164000);  // upper bank still hidden
    exp_start.raw              = STARTUP_RESET;
    exp_start.fields.rom_hi_en = 1'b1;
    write_word(16'o177716, exp_start.raw);
    read_expect(16'o177716, exp_start.raw, "startup rom_hi_en");
    rom_read(16'o164000);
    rom_read(16'o172776);
    exp_start.fields.rom_hi_en = 1'b0;
    exp_start.fields.rom_lo_en = 1'b0;
    write_word(16'o177716, exp_start.raw);
    ext_read(16'o160000);  // both enables off
    rom_read(16'o173000);

    // external bus and system ram window
    ext_read(16'o177576);
    ext_read(16'o177600);
    ext_read(16'o177677);
    ext_read(16'o177700);
    ext_read(16'o100000);
    ext_write(16'o177640, 16'h3C3C, 2'b01);
    ext_write(16'o001000, 16'hC3C3, 2'b10);

    // ********************
    // line clock and button
    check_bit("timer_status_o", timer_status_o, TIMER_INIT);
    irq_phases();
    hold_button(1'b1, 3, irq_highs);
    check_bit("timer_status_o pressed", timer_status_o, 1'b0);
    hold_button(1'b1, 2, irq_highs);  // still held, no second toggle
    check_bit("timer_status_o held", timer_status_o, 1'b0);
    check_count("line_irq_o high while off", irq_highs, 0);
    hold_button(1'b0, 3, irq_highs);
    check_bit("timer_status_o released", timer_status_o, 1'b0);
    check_count("line_irq_o high while off", irq_highs, 0);
    hold_button(1'b1, 3, irq_highs);
    check_bit("timer_status_o pressed again", timer_status_o, 1'b1);
    hold_button(1'b0, 3, irq_highs);
    irq_phases();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: design/rom_image.mem
// monitor rom image, one 16-bit hex word per entry
// @nnn is a word address, byte address is 160000 octal plus twice nnn
@000
00A0  // nop
15C6  // mov #1000, sp
0200
0A00  // clr r0, next word left blank
@400
15C0  // console entry at 164000
E800
0087  // rts pc
@AFF
01FF  // br . at the top of the middle bank
@B00
15C1  // loader at 173000, mov #177560, r1
FF70
0A00
@FFF
0087  // last word of the image

// File: project.f
design/board_pkg.sv
design/bus_decoder.sv
design/shadow_rom.sv
design/board_registers.sv
design/line_clock.sv
design/cpu_board.sv
test/cpu_board_tb.sv

// File: Makefile
SRCS := $(wildcard design/*.sv test/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vcpu_board_tb: project.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module cpu_board_tb -f project.f

run: obj_dir/Vcpu_board_tb
	./obj_dir/Vcpu_board_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Regression failed" sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
